// ==== include/rv_decode_defines.svh ====
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

`define XLEN 32

`define OPCODE_LUI      7'b0110111
`define OPCODE_AUIPC    7'b0010111
`define OPCODE_JAL      7'b1101111
`define OPCODE_JALR     7'b1100111
`define OPCODE_BRANCH   7'b1100011
`define OPCODE_LOAD     7'b0000011
`define OPCODE_STORE    7'b0100011
`define OPCODE_OP_IMM   7'b0010011
`define OPCODE_OP       7'b0110011
`define OPCODE_MISC_MEM 7'b0001111
`define OPCODE_SYSTEM   7'b1110011

`define F3_BEQ  3'b000
`define F3_BNE  3'b001
`define F3_BLT  3'b100
`define F3_BGE  3'b101
`define F3_BLTU 3'b110
`define F3_BGEU 3'b111

`define F3_LB  3'b000
`define F3_LH  3'b001
`define F3_LW  3'b010
`define F3_LBU 3'b100
`define F3_LHU 3'b101
`define F3_SB  3'b000
`define F3_SH  3'b001
`define F3_SW  3'b010

`define F3_ADD  3'b000
`define F3_SLL  3'b001
`define F3_SLT  3'b010
`define F3_SLTU 3'b011
`define F3_XOR  3'b100
`define F3_SRL  3'b101
`define F3_OR   3'b110
`define F3_AND  3'b111

`define F3_PRIV    3'b000
`define F3_CSRRW   3'b001
`define F3_CSRRS   3'b010
`define F3_CSRRC   3'b011
`define F3_CSRRWI  3'b101
`define F3_CSRRSI  3'b110
`define F3_CSRRCI  3'b111
`define F3_FENCE   3'b000
`define F3_FENCE_I 3'b001

`define F3_MUL    3'b000
`define F3_MULH   3'b001
`define F3_MULHSU 3'b010
`define F3_MULHU  3'b011
`define F3_DIV    3'b100
`define F3_DIVU   3'b101
`define F3_REM    3'b110
`define F3_REMU   3'b111

`define FUNCT7_BASE   7'b0000000
`define FUNCT7_ALT    7'b0100000
`define FUNCT7_MULDIV 7'b0000001

`define SYS_ECALL  12'h000
`define SYS_EBREAK 12'h001
`define SYS_MRET   12'h302
`define SYS_WFI    12'h105

// addi x0,x0,0
`define NOP_INSTR 32'h00000013

`endif

// ==== source/rv_decode_pkg.sv ====
`include "rv_decode_defines.svh"

package rv_decode_pkg;

  typedef logic [31:0]       instr_t;
  typedef logic [`XLEN-1:0]  xlen_t;
  typedef logic [4:0]        reg_addr_t;
  typedef logic [11:0]       csr_addr_t;

  typedef struct packed {
    logic add;
    logic sub;
    logic sll;
    logic slt;
    logic sltu;
    logic xor_op;
    logic srl;
    logic sra;
    logic or_op;
    logic and_op;
  } alu_op_t;

  typedef struct packed {
    logic beq;
    logic bne;
    logic blt;
    logic bge;
    logic bltu;
    logic bgeu;
  } bcu_op_t;

  typedef struct packed {
    logic lb;
    logic lh;
    logic lw;
    logic lbu;
    logic lhu;
    logic sb;
    logic sh;
    logic sw;
  } lsu_op_t;

  typedef struct packed {
    logic csrrw;
    logic csrrs;
    logic csrrc;
    logic csrrwi;
    logic csrrsi;
    logic csrrci;
  } csr_op_t;

  typedef struct packed {
    logic mul;
    logic mulh;
    logic mulhsu;
    logic mulhu;
  } mul_op_t;

  typedef struct packed {
    logic div;
    logic divu;
    logic rem;
    logic remu;
  } div_op_t;

  typedef struct packed {
    logic wren;   // rd write
    logic rden1;
    logic rden2;
    logic cwren;  // CSR write
    logic crden;  // CSR read
  } reg_use_t;

  typedef struct packed {
    logic lui;
    logic auipc;
    logic jal;
    logic jalr;
    logic branch;
    logic load;
    logic store;
    logic alu;
    logic nop;
    logic csreg;
    logic mult;
    logic division;
    logic fence;
    logic ecall;
    logic ebreak;
    logic mret;
    logic wfi;
  } class_t;

  typedef struct packed {
    xlen_t    imm;
    reg_use_t reg_use;
    class_t   cls;
    alu_op_t  alu_op;
    bcu_op_t  bcu_op;
    lsu_op_t  lsu_op;
    csr_op_t  csr_op;
    mul_op_t  mul_op;
    div_op_t  div_op;
    logic     legal;
  } decode_t;

endpackage

// ==== source/imm_gen.sv ====
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module imm_gen (
  input  rv_decode_pkg::instr_t instr,
  output rv_decode_pkg::xlen_t  imm
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  xlen_t      imm_c;

  assign opcode = instr[6:0];

  assign imm_i = {{20{instr[31]}}, instr[31:20]};
  assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u = {instr[31:12], 12'h000};
  assign imm_j = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
  assign imm_c = {27'h0, instr[19:15]};  // zimm of the CSR immediate forms

  always_comb begin
    case (opcode)
      `OPCODE_JALR, `OPCODE_LOAD, `OPCODE_OP_IMM: imm = imm_i;
      `OPCODE_STORE:                              imm = imm_s;
      `OPCODE_BRANCH:                             imm = imm_b;
      `OPCODE_LUI, `OPCODE_AUIPC:                 imm = imm_u;
      `OPCODE_JAL:                                imm = imm_j;
      `OPCODE_SYSTEM:                             imm = imm_c;
      default:                                    imm = '0;
    endcase
  end

endmodule

// ==== source/base_decoder.sv ====
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module base_decoder (
  input  rv_decode_pkg::instr_t   instr,
  output rv_decode_pkg::reg_use_t use_o,
  output rv_decode_pkg::class_t   cls,
  output rv_decode_pkg::alu_op_t  alu_op,
  output rv_decode_pkg::bcu_op_t  bcu_op,
  output rv_decode_pkg::lsu_op_t  lsu_op,
  output logic                    legal
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  logic       rd_nz;

  reg_use_t   use_d;
  class_t     cls_d;
  alu_op_t    alu_d;
  bcu_op_t    bcu_d;
  lsu_op_t    lsu_d;
  logic       ok;

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];
  assign rd     = instr[11:7];
  assign rd_nz  = |rd;

  always_comb begin
    use_d = '0;
    cls_d = '0;
    alu_d = '0;
    bcu_d = '0;
    lsu_d = '0;
    ok    = 1'b1;
    case (opcode)
      `OPCODE_LUI: begin
        use_d.wren = rd_nz;
        cls_d.lui  = 1'b1;
      end
      `OPCODE_AUIPC: begin
        use_d.wren  = rd_nz;
        cls_d.auipc = 1'b1;
      end
      `OPCODE_JAL: begin
        use_d.wren = rd_nz;
        cls_d.jal  = 1'b1;
      end
      `OPCODE_JALR: begin
        use_d.wren  = rd_nz;
        use_d.rden1 = 1'b1;
        cls_d.jalr  = 1'b1;
        ok          = (funct3 == 3'b000);
      end
      `OPCODE_BRANCH: begin
        use_d.rden1  = 1'b1;
        use_d.rden2  = 1'b1;
        cls_d.branch = 1'b1;
        case (funct3)
          `F3_BEQ:  bcu_d.beq  = 1'b1;
          `F3_BNE:  bcu_d.bne  = 1'b1;
          `F3_BLT:  bcu_d.blt  = 1'b1;
          `F3_BGE:  bcu_d.bge  = 1'b1;
          `F3_BLTU: bcu_d.bltu = 1'b1;
          `F3_BGEU: bcu_d.bgeu = 1'b1;
          default:  ok = 1'b0;
        endcase
      end
      `OPCODE_LOAD: begin
        use_d.wren  = rd_nz;
        use_d.rden1 = 1'b1;
        cls_d.load  = 1'b1;
        case (funct3)
          `F3_LB:  lsu_d.lb  = 1'b1;
          `F3_LH:  lsu_d.lh  = 1'b1;
          `F3_LW:  lsu_d.lw  = 1'b1;
          `F3_LBU: lsu_d.lbu = 1'b1;
          `F3_LHU: lsu_d.lhu = 1'b1;
          default: ok = 1'b0;
        endcase
      end
      `OPCODE_STORE: begin
        use_d.rden1 = 1'b1;
        use_d.rden2 = 1'b1;
        cls_d.store = 1'b1;
        case (funct3)
          `F3_SB:  lsu_d.sb = 1'b1;
          `F3_SH:  lsu_d.sh = 1'b1;
          `F3_SW:  lsu_d.sw = 1'b1;
          default: ok = 1'b0;
        endcase
      end
      `OPCODE_OP_IMM: begin
        use_d.wren  = rd_nz;
        use_d.rden1 = 1'b1;
        cls_d.alu   = 1'b1;
        case (funct3)
          `F3_ADD:  alu_d.add    = 1'b1;
          `F3_SLT:  alu_d.slt    = 1'b1;
          `F3_SLTU: alu_d.sltu   = 1'b1;
          `F3_XOR:  alu_d.xor_op = 1'b1;
          `F3_OR:   alu_d.or_op  = 1'b1;
          `F3_AND:  alu_d.and_op = 1'b1;
          `F3_SLL: begin
            alu_d.sll = 1'b1;
            ok        = (funct7 == `FUNCT7_BASE);
          end
          default: begin  // Funct7 picks srl or sra
            alu_d.srl = (funct7 == `FUNCT7_BASE);
            alu_d.sra = (funct7 == `FUNCT7_ALT);
            ok        = alu_d.srl | alu_d.sra;
          end
        endcase
      end
      `OPCODE_OP: begin
        use_d.wren  = rd_nz;
        use_d.rden1 = 1'b1;
        use_d.rden2 = 1'b1;
        cls_d.alu   = 1'b1;
        if (funct7 == `FUNCT7_BASE) begin
          case (funct3)
            `F3_ADD:  alu_d.add    = 1'b1;
            `F3_SLL:  alu_d.sll    = 1'b1;
            `F3_SLT:  alu_d.slt    = 1'b1;
            `F3_SLTU: alu_d.sltu   = 1'b1;
            `F3_XOR:  alu_d.xor_op = 1'b1;
            `F3_SRL:  alu_d.srl    = 1'b1;
            `F3_OR:   alu_d.or_op  = 1'b1;
            default:  alu_d.and_op = 1'b1;
          endcase
        end else if (funct7 == `FUNCT7_ALT && funct3 == `F3_ADD) begin
          alu_d.sub = 1'b1;
        end else if (funct7 == `FUNCT7_ALT && funct3 == `F3_SRL) begin
          alu_d.sra = 1'b1;
        end else begin
          ok = 1'b0;  // M-extension or unknown funct7
        end
      end
      default: ok = 1'b0;
    endcase

    if (instr == `NOP_INSTR) begin
      cls_d.nop = 1'b1;
      alu_d.add = 1'b0;
    end
  end

  assign legal  = ok;
  assign use_o  = ok ? use_d : '0;
  assign cls    = ok ? cls_d : '0;
  assign alu_op = ok ? alu_d : '0;
  assign bcu_op = ok ? bcu_d : '0;
  assign lsu_op = ok ? lsu_d : '0;

endmodule

// ==== source/muldiv_decoder.sv ====
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module muldiv_decoder (
  input  rv_decode_pkg::instr_t   instr,
  output rv_decode_pkg::reg_use_t use_o,
  output rv_decode_pkg::class_t   cls,
  output rv_decode_pkg::mul_op_t  mul_op,
  output rv_decode_pkg::div_op_t  div_op,
  output logic                    legal
);
  import rv_decode_pkg::*;

  reg_addr_t rd;
  logic      owned;

  assign rd    = instr[11:7];
  assign owned = (instr[6:0] == `OPCODE_OP) && (instr[31:25] == `FUNCT7_MULDIV);
  assign legal = owned;  // Every funct3 is a valid M op

  always_comb begin
    use_o  = '0;
    cls    = '0;
    mul_op = '0;
    div_op = '0;
    if (owned) begin
      use_o.wren  = |rd;
      use_o.rden1 = 1'b1;
      use_o.rden2 = 1'b1;
      case (instr[14:12])
        `F3_MUL:    mul_op.mul    = 1'b1;
        `F3_MULH:   mul_op.mulh   = 1'b1;
        `F3_MULHSU: mul_op.mulhsu = 1'b1;
        `F3_MULHU:  mul_op.mulhu  = 1'b1;
        `F3_DIV:    div_op.div    = 1'b1;
        `F3_DIVU:   div_op.divu   = 1'b1;
        `F3_REM:    div_op.rem    = 1'b1;
        default:    div_op.remu   = 1'b1;
      endcase
      cls.mult     = |mul_op;
      cls.division = |div_op;
    end
  end

endmodule

// ==== source/system_decoder.sv ====
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module system_decoder (
  input  rv_decode_pkg::instr_t   instr,
  output rv_decode_pkg::reg_use_t use_o,
  output rv_decode_pkg::class_t   cls,
  output rv_decode_pkg::csr_op_t  csr_op,
  output logic                    legal
);
  import rv_decode_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  csr_addr_t  funct12;
  reg_addr_t  rd;
  reg_addr_t  rs1;
  logic       rd_nz;
  logic       rs1_nz;  // Also zimm nonzero for the immediate forms

  reg_use_t   use_d;
  class_t     cls_d;
  csr_op_t    csr_d;
  logic       ok;

  assign opcode  = instr[6:0];
  assign funct3  = instr[14:12];
  assign funct12 = instr[31:20];
  assign rd      = instr[11:7];
  assign rs1     = instr[19:15];
  assign rd_nz   = |rd;
  assign rs1_nz  = |rs1;

  always_comb begin
    use_d = '0;
    cls_d = '0;
    csr_d = '0;
    ok    = 1'b1;
    case (opcode)
      `OPCODE_SYSTEM: begin
        if (funct3 == `F3_PRIV) begin
          case (funct12)
            `SYS_ECALL:  cls_d.ecall  = 1'b1;
            `SYS_EBREAK: cls_d.ebreak = 1'b1;
            `SYS_MRET:   cls_d.mret   = 1'b1;
            `SYS_WFI:    cls_d.wfi    = 1'b1;
            default:     ok = 1'b0;
          endcase
        end else begin
          use_d.wren = rd_nz;
          case (funct3)
            `F3_CSRRW: begin
              csr_d.csrrw = 1'b1;
              use_d.rden1 = 1'b1;
              use_d.cwren = 1'b1;
              use_d.crden = rd_nz;
            end
            `F3_CSRRS, `F3_CSRRC: begin
              csr_d.csrrs = (funct3 == `F3_CSRRS);
              csr_d.csrrc = (funct3 == `F3_CSRRC);
              use_d.rden1 = 1'b1;
              use_d.cwren = rs1_nz;  // rs1 = x0 only reads
              use_d.crden = 1'b1;
            end
            `F3_CSRRWI: begin
              csr_d.csrrwi = 1'b1;
              use_d.cwren  = 1'b1;
              use_d.crden  = rd_nz;
            end
            `F3_CSRRSI, `F3_CSRRCI: begin
              csr_d.csrrsi = (funct3 == `F3_CSRRSI);
              csr_d.csrrci = (funct3 == `F3_CSRRCI);
              use_d.cwren  = rs1_nz;
              use_d.crden  = 1'b1;
            end
            default: ok = 1'b0;
          endcase
          cls_d.csreg = |csr_d;
        end
      end
      `OPCODE_MISC_MEM: begin
        cls_d.fence = 1'b1;
        ok          = (funct3 == `F3_FENCE) || (funct3 == `F3_FENCE_I);
      end
      default: ok = 1'b0;
    endcase
  end

  assign legal  = ok;
  assign use_o  = ok ? use_d : '0;
  assign cls    = ok ? cls_d : '0;
  assign csr_op = ok ? csr_d : '0;

endmodule

// ==== source/decode_stage.sv ====
`timescale 1ns/1ns

module decode_stage (
  input  logic                   clock,
  input  logic                   rst_n,
  input  logic                   instr_valid,
  input  rv_decode_pkg::instr_t  instr,
  output logic                   dec_valid,
  output rv_decode_pkg::decode_t dec
);
  import rv_decode_pkg::*;

  xlen_t    imm;
  reg_use_t base_use;
  reg_use_t md_use;
  reg_use_t sys_use;
  class_t   base_cls;
  class_t   md_cls;
  class_t   sys_cls;
  alu_op_t  alu_op;
  bcu_op_t  bcu_op;
  lsu_op_t  lsu_op;
  csr_op_t  csr_op;
  mul_op_t  mul_op;
  div_op_t  div_op;
  logic     base_legal;
  logic     md_legal;
  logic     sys_legal;
  decode_t  dec_d;

  imm_gen u_imm_gen (
    .instr (instr),
    .imm   (imm)
  );

  base_decoder u_base_decoder (
    .instr  (instr),
    .use_o  (base_use),
    .cls    (base_cls),
    .alu_op (alu_op),
    .bcu_op (bcu_op),
    .lsu_op (lsu_op),
    .legal  (base_legal)
  );

  muldiv_decoder u_muldiv_decoder (
    .instr  (instr),
    .use_o  (md_use),
    .cls    (md_cls),
    .mul_op (mul_op),
    .div_op (div_op),
    .legal  (md_legal)
  );

  system_decoder u_system_decoder (
    .instr  (instr),
    .use_o  (sys_use),
    .cls    (sys_cls),
    .csr_op (csr_op),
    .legal  (sys_legal)
  );

  // Decoders own disjoint encodings, so OR merges them
  always_comb begin
    dec_d.imm     = imm;
    dec_d.reg_use = base_use | md_use | sys_use;
    dec_d.cls     = base_cls | md_cls | sys_cls;
    dec_d.alu_op  = alu_op;
    dec_d.bcu_op  = bcu_op;
    dec_d.lsu_op  = lsu_op;
    dec_d.csr_op  = csr_op;
    dec_d.mul_op  = mul_op;
    dec_d.div_op  = div_op;
    dec_d.legal   = base_legal | md_legal | sys_legal;
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
      dec       <= '0;
    end else begin
      dec_valid <= instr_valid;
      if (instr_valid) begin
        dec <= dec_d;  // Held until the next strobe
      end
    end
  end

  a_ops_onehot : assert property (@(posedge clock) disable iff (!rst_n)
    dec_valid |-> $onehot0(dec.alu_op) && $onehot0(dec.bcu_op) &&
                  $onehot0(dec.lsu_op) && $onehot0(dec.csr_op));

  a_muldiv_excl : assert property (@(posedge clock) disable iff (!rst_n)
    !((|dec.mul_op) && (|dec.div_op)));

  a_illegal_no_class : assert property (@(posedge clock) disable iff (!rst_n)
    (dec_valid && !dec.legal) |-> (dec.cls == '0));

endmodule

// ==== tests/decode_model.sv ====
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module decode_model (
  input  rv_decode_pkg::instr_t  instr,
  output rv_decode_pkg::decode_t expected
);
  import rv_decode_pkg::*;

  logic [6:0] op;
  logic [2:0] f3;
  logic [6:0] f7;
  logic       rd_nz;
  logic       rs1_nz;
  logic       csr_form;  // CSR access, not a privileged op

  assign op       = instr[6:0];
  assign f3       = instr[14:12];
  assign f7       = instr[31:25];
  assign rd_nz    = instr[11:7] != 5'd0;
  assign rs1_nz   = instr[19:15] != 5'd0;
  assign csr_form = (op == `OPCODE_SYSTEM) && (f3 != 3'b000);

  function automatic logic is_legal(input instr_t w);
    logic [2:0] fn3;
    logic [6:0] fn7;
    fn3 = w[14:12];
    fn7 = w[31:25];
    case (w[6:0])
      `OPCODE_LUI, `OPCODE_AUIPC, `OPCODE_JAL: return 1'b1;
      `OPCODE_JALR:     return fn3 == 3'b000;
      `OPCODE_BRANCH:   return fn3 != 3'b010 && fn3 != 3'b011;
      `OPCODE_LOAD:     return fn3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
      `OPCODE_STORE:    return fn3 <= 3'd2;
      `OPCODE_OP_IMM: begin
        if (fn3 == 3'd1)
          return fn7 == `FUNCT7_BASE;
        if (fn3 == 3'd5)
          return fn7 == `FUNCT7_BASE || fn7 == `FUNCT7_ALT;
        return 1'b1;
      end
      `OPCODE_OP: return fn7 == `FUNCT7_BASE || fn7 == `FUNCT7_MULDIV ||
                         (fn7 == `FUNCT7_ALT && (fn3 == 3'd0 || fn3 == 3'd5));
      `OPCODE_MISC_MEM: return fn3 <= 3'd1;
      `OPCODE_SYSTEM: begin
        if (fn3 == 3'd0)
          return w[31:20] inside {`SYS_ECALL, `SYS_EBREAK, `SYS_MRET, `SYS_WFI};
        return fn3 != 3'd4;
      end
      default: return 1'b0;
    endcase
  endfunction

  function automatic xlen_t pick_imm(input instr_t w);
    case (w[6:0])
      `OPCODE_JALR, `OPCODE_LOAD, `OPCODE_OP_IMM: return 32'($signed(w[31:20]));
      `OPCODE_STORE:  return 32'($signed({w[31:25], w[11:7]}));
      `OPCODE_BRANCH: return 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      `OPCODE_LUI, `OPCODE_AUIPC: return {w[31:12], 12'b0};
      `OPCODE_JAL:    return 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      `OPCODE_SYSTEM: return 32'(w[19:15]);
      default:        return '0;
    endcase
  endfunction

  function automatic alu_op_t alu_pick(input logic [2:0] fn3, input logic alt);
    alu_op_t a;
    a = '0;
    case (fn3)
      3'd0:    if (alt) a.sub = 1'b1; else a.add = 1'b1;
      3'd1:    a.sll = 1'b1;
      3'd2:    a.slt = 1'b1;
      3'd3:    a.sltu = 1'b1;
      3'd4:    a.xor_op = 1'b1;
      3'd5:    if (alt) a.sra = 1'b1; else a.srl = 1'b1;
      3'd6:    a.or_op = 1'b1;
      default: a.and_op = 1'b1;
    endcase
    return a;
  endfunction

  always_comb begin
    expected       = '0;
    expected.imm   = pick_imm(instr);
    expected.legal = is_legal(instr);
    if (expected.legal) begin
      case (op)
        `OPCODE_LUI:   expected.cls.lui = 1'b1;
        `OPCODE_AUIPC: expected.cls.auipc = 1'b1;
        `OPCODE_JAL:   expected.cls.jal = 1'b1;
        `OPCODE_JALR:  expected.cls.jalr = 1'b1;
        `OPCODE_BRANCH: begin
          expected.cls.branch = 1'b1;
          // beq bne, then blt..bgeu at funct3 4..7
          expected.bcu_op = f3[2] ? (6'b001000 >> f3[1:0]) : (6'b100000 >> f3[0]);
        end
        `OPCODE_LOAD: begin
          expected.cls.load = 1'b1;
          expected.lsu_op = f3[2] ? (8'b0001_0000 >> f3[0]) : (8'b1000_0000 >> f3[1:0]);
        end
        `OPCODE_STORE: begin
          expected.cls.store = 1'b1;
          expected.lsu_op    = 8'b0000_0100 >> f3;
        end
        `OPCODE_OP_IMM: begin
          expected.cls.alu    = 1'b1;
          expected.alu_op     = alu_pick(f3, f3 == 3'd5 && f7 == `FUNCT7_ALT);
        end
        `OPCODE_OP: begin
          if (f7 == `FUNCT7_MULDIV && f3[2]) begin
            expected.cls.division = 1'b1;
            expected.div_op       = 4'b1000 >> f3[1:0];
          end else if (f7 == `FUNCT7_MULDIV) begin
            expected.cls.mult = 1'b1;
            expected.mul_op   = 4'b1000 >> f3[1:0];
          end else begin
            expected.cls.alu = 1'b1;
            expected.alu_op  = alu_pick(f3, f7 == `FUNCT7_ALT);
          end
        end
        `OPCODE_MISC_MEM: expected.cls.fence = 1'b1;
        `OPCODE_SYSTEM: begin
          if (!csr_form) begin
            expected.cls.ecall  = instr[31:20] == `SYS_ECALL;
            expected.cls.ebreak = instr[31:20] == `SYS_EBREAK;
            expected.cls.mret   = instr[31:20] == `SYS_MRET;
            expected.cls.wfi    = instr[31:20] == `SYS_WFI;
          end else begin
            expected.cls.csreg  = 1'b1;
            expected.csr_op = f3[2] ? (6'b000100 >> (f3[1:0] - 2'd1)) :
                                      (6'b100000 >> (f3[1:0] - 2'd1));
          end
        end
        default: ;
      endcase

      expected.reg_use.wren = rd_nz && (csr_form || op inside {`OPCODE_LUI, `OPCODE_AUIPC,
        `OPCODE_JAL, `OPCODE_JALR, `OPCODE_LOAD, `OPCODE_OP_IMM, `OPCODE_OP});
      expected.reg_use.rden1 = (csr_form && !f3[2]) || op inside {`OPCODE_JALR,
        `OPCODE_BRANCH, `OPCODE_LOAD, `OPCODE_STORE, `OPCODE_OP_IMM, `OPCODE_OP};
      expected.reg_use.rden2 = op inside {`OPCODE_BRANCH, `OPCODE_STORE, `OPCODE_OP};
      if (csr_form) begin
        expected.reg_use.cwren = (f3[1:0] == 2'b01) ? 1'b1 : rs1_nz;  // rs1 field is zimm
        expected.reg_use.crden = (f3[1:0] == 2'b01) ? rd_nz : 1'b1;
      end

      if (instr == `NOP_INSTR) begin
        expected.cls.nop = 1'b1;
        expected.alu_op  = '0;
      end
    end
  end

endmodule

// ==== tests/tb_decode_stage.sv ====
`timescale 1ns/1ns
`include "rv_decode_defines.svh"

module tb_decode_stage;
  import rv_decode_pkg::*;

  localparam int N_INSTR        = 2000;
  localparam int TIMEOUT_CYCLES = N_INSTR * 3 / 2;  // Room for a 3/4 strobe rate
  localparam int SEED           = 58;

  logic    clock;
  logic    rst_n;
  logic    instr_valid;
  instr_t  instr;
  logic    dec_valid;
  decode_t dec;
  decode_t exp_dec;

  decode_t exp_q[$];
  instr_t  instr_q[$];
  decode_t last_dec = '0;
  logic    strobe_taken = 1'b0;
  int      cycle = 0;
  int      errors = 0;
  int      checks = 0;
  int      sent = 0;

  decode_stage uut (
    .clock       (clock),
    .rst_n       (rst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .dec_valid   (dec_valid),
    .dec         (dec)
  );

  decode_model ref_model (
    .instr    (instr),
    .expected (exp_dec)
  );

  always #20 clock = ~clock;

  function automatic instr_t enc_i(input logic [11:0] imm, input reg_addr_t rs1,
                                   input logic [2:0] f3, input reg_addr_t rd,
                                   input logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic instr_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input logic [2:0] f3,
                                   input reg_addr_t rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic reg_addr_t pick_reg();
    if ($urandom % 4 == 0)
      return 5'd0;  // x0 often enough to hit the zero rules
    return 5'($urandom);
  endfunction

  function automatic instr_t random_legal();
    instr_t      w;
    logic [2:0]  f3;
    logic        coin;
    int unsigned kind;
    w        = $urandom;
    w[11:7]  = pick_reg();
    w[19:15] = pick_reg();
    f3       = 3'($urandom);
    coin     = 1'($urandom);
    kind     = $urandom % 13;
    case (kind)
      0: w[6:0] = `OPCODE_LUI;
      1: w[6:0] = `OPCODE_AUIPC;
      2: w[6:0] = `OPCODE_JAL;
      3: w[6:0] = `OPCODE_JALR;
      4: w[6:0] = `OPCODE_BRANCH;
      5: w[6:0] = `OPCODE_LOAD;
      6: w[6:0] = `OPCODE_STORE;
      7, 8: w[6:0] = (kind == 7) ? `OPCODE_OP_IMM : `OPCODE_OP;
      9: w[6:0] = `OPCODE_OP;
      10, 11: w[6:0] = `OPCODE_SYSTEM;
      default: w[6:0] = `OPCODE_MISC_MEM;
    endcase
    case (kind)
      3: f3 = 3'd0;
      4: begin
        f3 = 3'($urandom % 6);
        if (f3 >= 3'd2) f3 = f3 + 3'd2;  // No branch at 2 and 3
      end
      5: begin
        f3 = 3'($urandom % 5);
        if (f3 >= 3'd3) f3 = f3 + 3'd1;
      end
      6: f3 = 3'($urandom % 3);
      7: begin
        if (f3 == 3'd1) w[31:25] = `FUNCT7_BASE;
        if (f3 == 3'd5) w[31:25] = coin ? `FUNCT7_ALT : `FUNCT7_BASE;
      end
      8: w[31:25] = (coin && (f3 == 3'd0 || f3 == 3'd5)) ? `FUNCT7_ALT : `FUNCT7_BASE;
      9: w[31:25] = `FUNCT7_MULDIV;
      10: begin
        f3 = 3'($urandom % 6) + 3'd1;
        if (f3 >= 3'd4) f3 = f3 + 3'd1;
      end
      11: begin
        f3 = 3'd0;
        case ($urandom % 4)
          0: w[31:20] = `SYS_ECALL;
          1: w[31:20] = `SYS_EBREAK;
          2: w[31:20] = `SYS_MRET;
          default: w[31:20] = `SYS_WFI;
        endcase
        w[19:15] = 5'd0;
        w[11:7]  = 5'd0;
      end
      12: f3 = {2'b00, f3[0]};
      default: ;
    endcase
    w[14:12] = f3;
    return w;
  endfunction

  task automatic send(input instr_t w);
    instr_valid = 1'b1;
    instr       = w;
    #1;
    exp_q.push_back(exp_dec);
    instr_q.push_back(w);
    sent++;
    @(posedge clock);
    #2;
  endtask

  task automatic idle();
    instr_valid = 1'b0;
    instr       = $urandom;  // Junk that must not be decoded
    @(posedge clock);
    #2;
  endtask

  task automatic compare_field(input string name, input instr_t w,
                               input logic [31:0] e, input logic [31:0] g);
    checks++;
    if (g !== e) begin
      errors++;
      $display("Error at %0t ns: %s for instr %h, expected %h, got %h",
               $time, name, w, e, g);
    end
  endtask

  task automatic compare_result(input instr_t w, input decode_t e);
    compare_field("imm", w, e.imm, dec.imm);
    compare_field("reg_use", w, 32'(e.reg_use), 32'(dec.reg_use));
    compare_field("cls", w, 32'(e.cls), 32'(dec.cls));
    compare_field("alu_op", w, 32'(e.alu_op), 32'(dec.alu_op));
    compare_field("bcu_op", w, 32'(e.bcu_op), 32'(dec.bcu_op));
    compare_field("lsu_op", w, 32'(e.lsu_op), 32'(dec.lsu_op));
    compare_field("csr_op", w, 32'(e.csr_op), 32'(dec.csr_op));
    compare_field("mul_op", w, 32'(e.mul_op), 32'(dec.mul_op));
    compare_field("div_op", w, 32'(e.div_op), 32'(dec.div_op));
    compare_field("legal", w, 32'(e.legal), 32'(dec.legal));
  endtask

  task automatic check_cycle();
    decode_t e;
    instr_t  w;
    checks++;
    if (dec_valid !== strobe_taken) begin
      errors++;
      $display("Error at %0t ns: dec_valid is %b, expected %b", $time, dec_valid, strobe_taken);
    end
    if (dec_valid === 1'b1) begin
      if (exp_q.size() == 0) begin
        errors++;
        $display("dec_valid went high at %0t ns with no instruction in flight", $time);
      end else begin
        e = exp_q.pop_front();
        w = instr_q.pop_front();
        compare_result(w, e);
        last_dec = e;
      end
    end else if (dec !== last_dec) begin
      errors++;
      $display("Error at %0t ns: dec changed while dec_valid was low", $time);
    end
  endtask

  task automatic run_directed();
    send(`NOP_INSTR);  // Back to back
    send(`NOP_INSTR);
    send(`NOP_INSTR);
    send(enc_i(12'h005, 5'd0, `F3_ADD, 5'd0, `OPCODE_OP_IMM));
    send(enc_i(12'h005, 5'd3, `F3_ADD, 5'd7, `OPCODE_OP_IMM));
    send(enc_r(`FUNCT7_BASE, 5'd2, 5'd1, `F3_ADD, 5'd0, `OPCODE_OP));
    send(enc_r(`FUNCT7_ALT, 5'd2, 5'd1, `F3_ADD, 5'd9, `OPCODE_OP));
    send({20'hABCDE, 5'd0, `OPCODE_LUI});
    send({20'hABCDE, 5'd4, `OPCODE_LUI});
    send({20'h80001, 5'd0, `OPCODE_JAL});
    send({20'h80001, 5'd1, `OPCODE_JAL});
    send(enc_r(`FUNCT7_MULDIV, 5'd3, 5'd2, `F3_MUL, 5'd0, `OPCODE_OP));
    send(enc_r(`FUNCT7_MULDIV, 5'd3, 5'd2, `F3_DIV, 5'd6, `OPCODE_OP));
    idle();
    // CSR enables with zero and nonzero rd, rs1 and zimm
    send(enc_i(12'h300, 5'd1, `F3_CSRRW, 5'd0, `OPCODE_SYSTEM));
    send(enc_i(12'h300, 5'd1, `F3_CSRRW, 5'd5, `OPCODE_SYSTEM));
    send(enc_i(12'h341, 5'd0, `F3_CSRRS, 5'd5, `OPCODE_SYSTEM));
    send(enc_i(12'h341, 5'd4, `F3_CSRRS, 5'd5, `OPCODE_SYSTEM));
    send(enc_i(12'h304, 5'd0, `F3_CSRRC, 5'd0, `OPCODE_SYSTEM));
    send(enc_i(12'h304, 5'd8, `F3_CSRRC, 5'd2, `OPCODE_SYSTEM));
    send(enc_i(12'h305, 5'd3, `F3_CSRRWI, 5'd0, `OPCODE_SYSTEM));
    send(enc_i(12'h305, 5'd3, `F3_CSRRWI, 5'd2, `OPCODE_SYSTEM));
    send(enc_i(12'h344, 5'd0, `F3_CSRRSI, 5'd6, `OPCODE_SYSTEM));
    send(enc_i(12'h344, 5'd17, `F3_CSRRSI, 5'd6, `OPCODE_SYSTEM));
    send(enc_i(12'h344, 5'd0, `F3_CSRRCI, 5'd0, `OPCODE_SYSTEM));
    send(enc_i(12'h344, 5'd31, `F3_CSRRCI, 5'd0, `OPCODE_SYSTEM));
    idle();
    send(enc_i(`SYS_ECALL, 5'd0, `F3_PRIV, 5'd0, `OPCODE_SYSTEM));
    send(enc_i(`SYS_EBREAK, 5'd0, `F3_PRIV, 5'd0, `OPCODE_SYSTEM));
    send(enc_i(`SYS_MRET, 5'd0, `F3_PRIV, 5'd0, `OPCODE_SYSTEM));
    send(enc_i(`SYS_WFI, 5'd0, `F3_PRIV, 5'd0, `OPCODE_SYSTEM));
    send(enc_i(12'h7FF, 5'd0, `F3_PRIV, 5'd0, `OPCODE_SYSTEM));
    send(enc_i(12'h300, 5'd1, 3'b100, 5'd1, `OPCODE_SYSTEM));
    send(enc_i(12'h0FF, 5'd0, `F3_FENCE, 5'd0, `OPCODE_MISC_MEM));
    send(enc_i(12'h000, 5'd0, `F3_FENCE_I, 5'd0, `OPCODE_MISC_MEM));
    send(enc_i(12'h0FF, 5'd0, 3'b010, 5'd0, `OPCODE_MISC_MEM));
    send(enc_i(12'h0FF, 5'd0, 3'b111, 5'd0, `OPCODE_MISC_MEM));
    send(enc_r(7'h10, 5'd2, 5'd1, `F3_ADD, 5'd3, `OPCODE_OP));
    send(enc_r(`FUNCT7_ALT, 5'd2, 5'd1, `F3_XOR, 5'd3, `OPCODE_OP));
    idle();
  endtask

  // Cycle count and timeout
  always @(posedge clock) begin
    cycle = cycle + 1;
    strobe_taken = rst_n && instr_valid;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks: %0d, errors: %0d", checks, errors);
      $display("Errors found");
      $finish;
    end
  end

  always @(negedge clock) begin
    if (cycle > 0)
      check_cycle();
  end

  initial begin
    instr_t w;
    clock       = 1'b0;
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    void'($urandom(SEED));
    repeat (3) @(posedge clock);
    #2;
    rst_n = 1'b1;
    repeat (4) idle();  // No strobe, no result
    run_directed();
    while (sent < N_INSTR) begin
      if ($urandom % 4 != 0) begin
        if ($urandom % 3 == 0)
          w = $urandom;
        else
          w = random_legal();
        send(w);
      end else begin
        idle();
      end
    end
    repeat (3) idle();
    if (exp_q.size() != 0) begin
      errors++;
      $display("%0d results were still pending at the end of the run", exp_q.size());
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== filelist.f ====
+incdir+include
source/rv_decode_pkg.sv
source/imm_gen.sv
source/base_decoder.sv
source/muldiv_decoder.sv
source/system_decoder.sv
source/decode_stage.sv
tests/decode_model.sv
tests/tb_decode_stage.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_decode_stage
FILELIST  ?= filelist.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator and run it, passes on No errors"
	@echo "  clean  remove $(BUILD_DIR)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$($(BUILD_DIR)/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "No errors"

clean:
	rm -rf $(BUILD_DIR)
